// ==== rtl/rbk_reg_pkg.sv ====
// rubik register file: shared register map, field widths and bus structs
package rbk_reg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int csb_addr_w   = 22;   // csb word address
  localparam int reg_offset_w = 12;   // byte offset inside the 4KB space
  localparam int data_w       = 32;
  localparam int addr_low_w   = 27;   // 32B aligned address, also line stride
  localparam int dim_w        = 13;   // width / height / channel

  ////////////////////////////////////////////////////////////////////////////
  // register map, byte offsets
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [reg_offset_w-1:0] ofs_status           = 12'h000;
  localparam logic [reg_offset_w-1:0] ofs_pointer          = 12'h004;
  localparam logic [reg_offset_w-1:0] ofs_group_base       = 12'h008; // ping-pong from here up
  localparam logic [reg_offset_w-1:0] ofs_op_enable        = 12'h008;
  localparam logic [reg_offset_w-1:0] ofs_misc_cfg         = 12'h00c; // mode 1:0, prec 9:8
  localparam logic [reg_offset_w-1:0] ofs_datain_size_0    = 12'h010; // width 12:0, height 28:16
  localparam logic [reg_offset_w-1:0] ofs_datain_size_1    = 12'h014; // channel 12:0
  localparam logic [reg_offset_w-1:0] ofs_dain_addr_low    = 12'h018; // bits 31:5
  localparam logic [reg_offset_w-1:0] ofs_dain_line_stride = 12'h01c; // bits 31:5
  localparam logic [reg_offset_w-1:0] ofs_perf_enable      = 12'h020;

  localparam int op_en_delay = 3;     // stages from armed to reg2dp_op_en

  // per-group status codes
  localparam logic [1:0] stat_idle    = 2'd0;
  localparam logic [1:0] stat_running = 2'd1;
  localparam logic [1:0] stat_pending = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [1:0]            level;
    logic [3:0]            wrbe;     // byte enables, not honoured
    logic                  srcpriv;
    logic                  nposted;  // non-posted write wants an ack
    logic                  write;
    logic [data_w-1:0]     wdat;
    logic [csb_addr_w-1:0] addr;     // word address
  } csb_req_t;

  typedef struct packed {
    logic              wr_ack;       // 1: write ack, 0: read data
    logic              error;
    logic [data_w-1:0] rdat;
  } csb_resp_t;

  typedef struct packed {
    logic [reg_offset_w-1:0] offset; // byte offset
    logic [data_w-1:0]       wr_data;
    logic                    wr;     // write strobe before group select
  } reg_access_t;

  typedef struct packed {
    logic [addr_low_w-1:0] dain_addr_low;
    logic [addr_low_w-1:0] dain_line_stride;
    logic [dim_w-1:0]      datain_width;
    logic [dim_w-1:0]      datain_height;
    logic [dim_w-1:0]      datain_channel;
    logic [1:0]            rubik_mode;
    logic [1:0]            in_precision;
    logic                  perf_en;
  } layer_cfg_t;

endpackage

// ==== rtl/rbk_csb_port.sv ====
// rubik csb port: request capture, group decode, read merge and response
`timescale 1ns/1ps
module rbk_csb_port (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           req_pvld,
  input  rbk_reg_pkg::csb_req_t          req_pd,
  input  logic                           producer,
  input  logic                           d0_armed,
  input  logic                           d1_armed,
  input  logic [rbk_reg_pkg::data_w-1:0] s_rd_data,
  input  logic [rbk_reg_pkg::data_w-1:0] d0_rd_data,
  input  logic [rbk_reg_pkg::data_w-1:0] d1_rd_data,
  output logic                           req_prdy,
  output logic                           resp_valid,
  output rbk_reg_pkg::csb_resp_t         resp_pd,
  output rbk_reg_pkg::reg_access_t       access,
  output logic                           s_wr_en,
  output logic                           d0_wr_en,
  output logic                           d1_wr_en
);
  import rbk_reg_pkg::*;

  logic              req_pvld_q;
  csb_req_t          req_q;
  logic              rd_en;
  logic              np_wr_en;
  logic              select_s;
  logic              select_d0;
  logic              select_d1;
  logic [data_w-1:0] rd_data;

  assign req_prdy = 1'b1; // never back-pressures

  ////////////////////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld_q <= 1'b0;
    end else begin
      req_pvld_q <= req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_q <= req_pd; // payload only
    end
  end

  // word address to byte offset, only the low 4KB matters
  assign access = '{offset:  {req_q.addr[reg_offset_w-3:0], 2'b00},
                    wr_data: req_q.wdat,
                    wr:      req_pvld_q & req_q.write};

  assign rd_en    = req_pvld_q & ~req_q.write;
  assign np_wr_en = access.wr & req_q.nposted;

  ////////////////////////////////////////////////////////////////////////////
  // group decode
  ////////////////////////////////////////////////////////////////////////////
  assign select_s  = (access.offset < ofs_group_base);
  assign select_d0 = ~select_s & ~producer;  // producer picks the ping-pong side
  assign select_d1 = ~select_s & producer;

  assign s_wr_en  = access.wr & select_s;
  assign d0_wr_en = access.wr & select_d0 & ~d0_armed; // locked while armed
  assign d1_wr_en = access.wr & select_d1 & ~d1_armed;

  // one select is hot, so an or-merge is enough
  assign rd_data = ({data_w{select_s}}  & s_rd_data)  |
                   ({data_w{select_d0}} & d0_rd_data) |
                   ({data_w{select_d1}} & d1_rd_data);

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rd_en | np_wr_en; // posted writes stay silent
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      resp_pd <= '{wr_ack: 1'b0, error: 1'b0, rdat: rd_data};
    end else if (np_wr_en) begin
      resp_pd <= '{wr_ack: 1'b1, error: 1'b0, rdat: '0}; // write ack carries no data
    end
  end

endmodule

// ==== rtl/rbk_pointer_group.sv ====
// rubik single group: producer/consumer pointers and status readback
`timescale 1ns/1ps
module rbk_pointer_group (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  rbk_reg_pkg::reg_access_t       access,
  input  logic                           wr_en,
  input  logic                           done,
  input  logic                           d0_armed,
  input  logic                           d1_armed,
  output logic [rbk_reg_pkg::data_w-1:0] rd_data,
  output logic                           producer,
  output logic                           consumer
);
  import rbk_reg_pkg::*;

  logic [1:0] status_0;
  logic [1:0] status_1;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (wr_en && access.offset == ofs_pointer) begin
        producer <= access.wr_data[0];
      end
      if (done) begin
        consumer <= ~consumer; // hand over to the other group
      end
    end
  end

  // armed and consumed -> running, armed and waiting -> pending
  assign status_0 = !d0_armed ? stat_idle :
                    !consumer ? stat_running : stat_pending;
  assign status_1 = !d1_armed ? stat_idle :
                    consumer  ? stat_running : stat_pending;

  always_comb begin
    rd_data = '0; // unmapped reads 0
    case (access.offset)
      ofs_status: begin
        rd_data[1:0]   = status_0;
        rd_data[17:16] = status_1;
      end
      ofs_pointer: begin
        rd_data[0]  = producer;
        rd_data[16] = consumer;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/rbk_layer_group.sv ====
// rubik ping-pong group: layer configuration fields and op-enable arming
`timescale 1ns/1ps
module rbk_layer_group (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  rbk_reg_pkg::reg_access_t       access,
  input  logic                           wr_en,
  input  logic                           disarm,
  output logic [rbk_reg_pkg::data_w-1:0] rd_data,
  output rbk_reg_pkg::layer_cfg_t        cfg,
  output logic                           armed
);
  import rbk_reg_pkg::*;

  logic arm_req;

  // wr_en already masked by armed in the port
  assign arm_req = wr_en & (access.offset == ofs_op_enable) & access.wr_data[0];

  ////////////////////////////////////////////////////////////////////////////
  // field writes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (access.offset)
        ofs_misc_cfg: begin
          cfg.rubik_mode   <= access.wr_data[1:0];
          cfg.in_precision <= access.wr_data[9:8];
        end
        ofs_datain_size_0: begin
          cfg.datain_width  <= access.wr_data[dim_w-1:0];
          cfg.datain_height <= access.wr_data[16 +: dim_w];
        end
        ofs_datain_size_1:    cfg.datain_channel   <= access.wr_data[dim_w-1:0];
        ofs_dain_addr_low:    cfg.dain_addr_low    <= access.wr_data[data_w-1:5];
        ofs_dain_line_stride: cfg.dain_line_stride <= access.wr_data[data_w-1:5];
        ofs_perf_enable:      cfg.perf_en          <= access.wr_data[0];
        default: ;
      endcase
    end
  end

  // arm has priority, it only lands while disarmed anyway
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      armed <= 1'b0;
    end else if (arm_req) begin
      armed <= 1'b1;
    end else if (disarm) begin
      armed <= 1'b0; // layer done
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    case (access.offset)
      ofs_op_enable: rd_data[0] = armed;
      ofs_misc_cfg: begin
        rd_data[1:0] = cfg.rubik_mode;
        rd_data[9:8] = cfg.in_precision;
      end
      ofs_datain_size_0: begin
        rd_data[dim_w-1:0]  = cfg.datain_width;
        rd_data[16 +: dim_w] = cfg.datain_height;
      end
      ofs_datain_size_1:    rd_data[dim_w-1:0]    = cfg.datain_channel;
      ofs_dain_addr_low:    rd_data[data_w-1:5]   = cfg.dain_addr_low;
      ofs_dain_line_stride: rd_data[data_w-1:5]   = cfg.dain_line_stride;
      ofs_perf_enable:      rd_data[0]            = cfg.perf_en;
      default: ;
    endcase
  end

endmodule

// ==== rtl/rbk_op_ctrl.sv ====
// rubik op control: consumer-selected op enable, disarm and clock-gate enable
`timescale 1ns/1ps
module rbk_op_ctrl (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       done,
  input  logic       consumer,
  input  logic       d0_armed,
  input  logic       d1_armed,
  output logic       d0_disarm,
  output logic       d1_disarm,
  output logic       op_en,
  output logic [2:0] slcg_op_en
);
  import rbk_reg_pkg::*;

  logic                        sel_armed;
  logic [op_en_delay-1:0]      op_en_pipe;
  logic [op_en_delay-1:0][2:0] slcg_pipe;

  // the group being consumed drives the datapath
  assign sel_armed = consumer ? d1_armed : d0_armed;

  // done retires the consumed group, same edge the consumer flips
  assign d0_disarm = done & ~consumer;
  assign d1_disarm = done & consumer;

  ////////////////////////////////////////////////////////////////////////////
  // op enable pipe
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (done) begin
      op_en_pipe <= '0; // drop op_en right after done
    end else begin
      op_en_pipe <= {op_en_pipe[op_en_delay-2:0], sel_armed};
    end
  end

  assign op_en = op_en_pipe[op_en_delay-1];

  ////////////////////////////////////////////////////////////////////////////
  // clock gating enable
  ////////////////////////////////////////////////////////////////////////////
  // not cleared by done, so clocks keep running until the
  // selected bit has been low for the whole delay
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      slcg_pipe <= '0;
    end else begin
      slcg_pipe <= {slcg_pipe[op_en_delay-2:0], {3{sel_armed}}};
    end
  end

  assign slcg_op_en = slcg_pipe[op_en_delay-1]; // one copy per gated clock

endmodule

// ==== rtl/rbk_regfile.sv ====
// rubik register file top: csb port, pointer group, two layer groups, op control
`timescale 1ns/1ps
module rbk_regfile (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      csb2rbk_req_pvld,
  input  rbk_reg_pkg::csb_req_t     csb2rbk_req_pd,
  input  logic                      dp2reg_done,
  output logic                      csb2rbk_req_prdy,
  output logic                      rbk2csb_resp_valid,
  output rbk_reg_pkg::csb_resp_t    rbk2csb_resp_pd,
  output rbk_reg_pkg::layer_cfg_t   reg2dp_cfg,
  output logic                      reg2dp_op_en,
  output logic [2:0]                slcg_op_en,
  output logic                      dp2reg_consumer
);
  import rbk_reg_pkg::*;

  reg_access_t       access;
  logic              s_wr_en;
  logic              d0_wr_en;
  logic              d1_wr_en;
  logic [data_w-1:0] s_rd_data;
  logic [data_w-1:0] d0_rd_data;
  logic [data_w-1:0] d1_rd_data;
  logic              producer;
  logic              d0_armed;
  logic              d1_armed;
  logic              d0_disarm;
  logic              d1_disarm;
  layer_cfg_t        d0_cfg;
  layer_cfg_t        d1_cfg;

  ////////////////////////////////////////////////////////////////////////////
  // csb access
  ////////////////////////////////////////////////////////////////////////////
  rbk_csb_port u_csb_port (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_pvld        (csb2rbk_req_pvld),
    .req_pd          (csb2rbk_req_pd),
    .producer        (producer),
    .d0_armed        (d0_armed),
    .d1_armed        (d1_armed),
    .s_rd_data       (s_rd_data),
    .d0_rd_data      (d0_rd_data),
    .d1_rd_data      (d1_rd_data),
    .req_prdy        (csb2rbk_req_prdy),
    .resp_valid      (rbk2csb_resp_valid),
    .resp_pd         (rbk2csb_resp_pd),
    .access          (access),
    .s_wr_en         (s_wr_en),
    .d0_wr_en        (d0_wr_en),
    .d1_wr_en        (d1_wr_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // register groups
  ////////////////////////////////////////////////////////////////////////////
  rbk_pointer_group u_pointer (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .access          (access),
    .wr_en           (s_wr_en),
    .done            (dp2reg_done),
    .d0_armed        (d0_armed),
    .d1_armed        (d1_armed),
    .rd_data         (s_rd_data),
    .producer        (producer),
    .consumer        (dp2reg_consumer)
  );

  rbk_layer_group u_layer_d0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .access          (access),
    .wr_en           (d0_wr_en),
    .disarm          (d0_disarm),
    .rd_data         (d0_rd_data),
    .cfg             (d0_cfg),
    .armed           (d0_armed)
  );

  rbk_layer_group u_layer_d1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .access          (access),
    .wr_en           (d1_wr_en),
    .disarm          (d1_disarm),
    .rd_data         (d1_rd_data),
    .cfg             (d1_cfg),
    .armed           (d1_armed)
  );

  rbk_op_ctrl u_op_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .done            (dp2reg_done),
    .consumer        (dp2reg_consumer),
    .d0_armed        (d0_armed),
    .d1_armed        (d1_armed),
    .d0_disarm       (d0_disarm),
    .d1_disarm       (d1_disarm),
    .op_en           (reg2dp_op_en),
    .slcg_op_en      (slcg_op_en)
  );

  // datapath sees the consumed group
  assign reg2dp_cfg = dp2reg_consumer ? d1_cfg : d0_cfg;

endmodule

// ==== bench/rbk_regfile_checker.sv ====
// rubik register file checker: csb response, op enable and clock gate properties
`timescale 1ns/1ps
module rbk_regfile_checker (
  input logic                   nvdla_core_clk,
  input logic                   nvdla_core_rstn,
  input logic                   csb2rbk_req_pvld,
  input rbk_reg_pkg::csb_req_t  csb2rbk_req_pd,
  input logic                   csb2rbk_req_prdy,
  input logic                   rbk2csb_resp_valid,
  input rbk_reg_pkg::csb_resp_t rbk2csb_resp_pd,
  input logic                   dp2reg_done,
  input logic                   dp2reg_consumer,
  input logic                   d0_armed,
  input logic                   d1_armed,
  input logic                   reg2dp_op_en,
  input logic [2:0]             slcg_op_en
);

  // one counter per property, summed for the testbench
  int   n_rdy = 0;
  int   n_resp = 0;
  int   n_posted = 0;
  int   n_done = 0;
  int   n_lat = 0;
  int   n_slcg = 0;
  int   n_fail;
  logic req_write;
  logic wants_resp;
  logic resp_ack;
  logic sel_armed;

  assign n_fail     = n_rdy + n_resp + n_posted + n_done + n_lat + n_slcg;
  assign req_write  = csb2rbk_req_pd.write;
  assign wants_resp = ~csb2rbk_req_pd.write | csb2rbk_req_pd.nposted; // read or np write
  assign resp_ack   = rbk2csb_resp_pd.wr_ack;
  assign sel_armed  = dp2reg_consumer ? d1_armed : d0_armed;           // consumed group

  ////////////////////////////////////////////////////////////////////////////
  // csb side
  ////////////////////////////////////////////////////////////////////////////
  a_prdy_high: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb2rbk_req_prdy)
    else begin n_rdy++; $error("csb request ready went low"); end

  // request capture, then response flop
  a_resp_latency: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (csb2rbk_req_pvld && wants_resp) |->
      ##2 (rbk2csb_resp_valid && resp_ack == $past(req_write, 2)))
    else begin n_resp++; $error("missing csb response or wrong ack bit"); end

  a_posted_silent: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (csb2rbk_req_pvld && !wants_resp) |-> ##2 !rbk2csb_resp_valid)
    else begin n_posted++; $error("posted write got a response"); end

  ////////////////////////////////////////////////////////////////////////////
  // op enable and clock gating
  ////////////////////////////////////////////////////////////////////////////
  a_done_drops_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |=> !reg2dp_op_en)
    else begin n_done++; $error("op enable still high after done"); end

  // start of a consumed armed bit, from arming or from a done handover
  a_op_en_latency: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (sel_armed && !dp2reg_done && (!$past(sel_armed) || $past(dp2reg_done))) |->
      ##2 !reg2dp_op_en ##1 reg2dp_op_en)
    else begin n_lat++; $error("op enable did not rise three cycles after arming"); end

  a_slcg_equal: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    slcg_op_en == {3{slcg_op_en[0]}})
    else begin n_slcg++; $error("clock gate enable bits differ"); end

endmodule

bind rbk_regfile rbk_regfile_checker u_checker (
  .nvdla_core_clk     (nvdla_core_clk),
  .nvdla_core_rstn    (nvdla_core_rstn),
  .csb2rbk_req_pvld   (csb2rbk_req_pvld),
  .csb2rbk_req_pd     (csb2rbk_req_pd),
  .csb2rbk_req_prdy   (csb2rbk_req_prdy),
  .rbk2csb_resp_valid (rbk2csb_resp_valid),
  .rbk2csb_resp_pd    (rbk2csb_resp_pd),
  .dp2reg_done        (dp2reg_done),
  .dp2reg_consumer    (dp2reg_consumer),
  .d0_armed           (d0_armed),
  .d1_armed           (d1_armed),
  .reg2dp_op_en       (reg2dp_op_en),
  .slcg_op_en         (slcg_op_en)
);

// ==== bench/rbk_regfile_tb.sv ====
// rubik register file testbench: csb programming, ping-pong handover, op enable
`timescale 1ns/1ps
module rbk_regfile_tb;
  import rbk_reg_pkg::*;

  localparam int max_cycles = 4000; // six tests of a few hundred cycles at most
  localparam int resp_wait  = 8;    // csb response is due two cycles after the request

  logic             nvdla_core_clk;
  logic             nvdla_core_rstn;
  logic             csb2rbk_req_pvld;
  csb_req_t         csb2rbk_req_pd;
  logic             dp2reg_done;
  logic             csb2rbk_req_prdy;
  logic             rbk2csb_resp_valid;
  csb_resp_t        rbk2csb_resp_pd;
  layer_cfg_t       reg2dp_cfg;
  logic             reg2dp_op_en;
  logic [2:0]       slcg_op_en;
  logic             dp2reg_consumer;
  integer           seed;
  int               cycles;
  int               errors;
  int               errors_at_start;
  int               tests_run;
  int               tests_failed;
  logic [5:0][31:0] set_a;            // group 0 field words
  logic [5:0][31:0] set_b;            // group 1 field words

  rbk_regfile u_dut (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2rbk_req_pvld   (csb2rbk_req_pvld),
    .csb2rbk_req_pd     (csb2rbk_req_pd),
    .dp2reg_done        (dp2reg_done),
    .csb2rbk_req_prdy   (csb2rbk_req_prdy),
    .rbk2csb_resp_valid (rbk2csb_resp_valid),
    .rbk2csb_resp_pd    (rbk2csb_resp_pd),
    .reg2dp_cfg         (reg2dp_cfg),
    .reg2dp_op_en       (reg2dp_op_en),
    .slcg_op_en         (slcg_op_en),
    .dp2reg_consumer    (dp2reg_consumer)
  );

  initial nvdla_core_clk = 1'b0;
  always #2 nvdla_core_clk = ~nvdla_core_clk; // 4 ns period

  always @(posedge nvdla_core_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // field map and expected values
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [11:0] field_offset(input int i);
    case (i)
      0: return ofs_misc_cfg;
      1: return ofs_datain_size_0;
      2: return ofs_datain_size_1;
      3: return ofs_dain_addr_low;
      4: return ofs_dain_line_stride;
      default: return ofs_perf_enable;
    endcase
  endfunction

  function automatic logic [31:0] field_mask(input int i);
    case (i)
      0: return 32'h0000_0303;    // mode 1:0, precision 9:8
      1: return 32'h1fff_1fff;    // width 12:0, height 28:16
      2: return 32'h0000_1fff;    // channel
      3, 4: return 32'hffff_ffe0; // 32B aligned
      default: return 32'h0000_0001;
    endcase
  endfunction

  function automatic layer_cfg_t expected_cfg(input logic [5:0][31:0] w);
    layer_cfg_t c;
    c.rubik_mode       = w[0][1:0];
    c.in_precision     = w[0][9:8];
    c.datain_width     = w[1][12:0];
    c.datain_height    = w[1][28:16];
    c.datain_channel   = w[2][12:0];
    c.dain_addr_low    = w[3][31:5];
    c.dain_line_stride = w[4][31:5];
    c.perf_en          = w[5][0];
    return c;
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_checker.n_fail; // tb checks plus bound properties
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %08h, expected %08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cfg(input layer_cfg_t got, input layer_cfg_t exp);
    assert (got === exp) else begin
      $display("FAILED reg2dp_cfg: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // csb driver
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_req(input logic [11:0] ofs, input logic wr, input logic np,
                          input logic [31:0] data);
    @(posedge nvdla_core_clk);
    csb2rbk_req_pvld <= 1'b1;
    csb2rbk_req_pd   <= '{level: 2'd0, wrbe: 4'hf, srcpriv: 1'b0, nposted: np,
                          write: wr, wdat: data, addr: {12'd0, ofs[11:2]}};
    @(posedge nvdla_core_clk);
    csb2rbk_req_pvld <= 1'b0;
  endtask

  task automatic wait_resp(output csb_resp_t resp);
    int n;
    n = 0;
    resp = '0;
    @(negedge nvdla_core_clk);
    while (!rbk2csb_resp_valid && n < resp_wait) begin
      @(negedge nvdla_core_clk);
      n++;
    end
    if (rbk2csb_resp_valid) begin
      resp = rbk2csb_resp_pd;
    end else begin
      $display("no csb response within %0d cycles", resp_wait);
      errors++;
    end
  endtask

  task automatic reg_write(input logic [11:0] ofs, input logic [31:0] data);
    send_req(ofs, 1'b1, 1'b0, data); // posted, no response
  endtask

  task automatic reg_write_np(input logic [11:0] ofs, input logic [31:0] data);
    csb_resp_t r;
    send_req(ofs, 1'b1, 1'b1, data);
    wait_resp(r);
    check_word("rbk2csb_resp_pd.wr_ack", 32'(r.wr_ack), 32'd1);
    check_word("rbk2csb_resp_pd.rdat", r.rdat, 32'd0);
  endtask

  task automatic read_check(input logic [11:0] ofs, input logic [31:0] exp);
    csb_resp_t r;
    send_req(ofs, 1'b0, 1'b0, 32'd0);
    wait_resp(r);
    check_word("rbk2csb_resp_pd.rdat", r.rdat, exp);
  endtask

  task automatic wait_op_en(input logic level);
    int n;
    n = 0;
    while (reg2dp_op_en !== level && n < 10) begin
      @(negedge nvdla_core_clk);
      n++;
    end
    if (reg2dp_op_en !== level) begin
      $display("reg2dp_op_en never reached %0d", level);
      errors++;
    end
  endtask

  task automatic pulse_done();
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b1;
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b0;
    @(negedge nvdla_core_clk); // first cycle after done is sampled
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errors() - errors_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("test %0d %-18s %0d error(s)", tests_run, name, n);
    errors_at_start = total_errors();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    seed = 57;
    cycles = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    nvdla_core_rstn = 1'b0;
    csb2rbk_req_pvld = 1'b0;
    csb2rbk_req_pd = '0;
    dp2reg_done = 1'b0;
    repeat (5) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    errors_at_start = total_errors();

    // group 0 readback, producer is 0 after reset
    for (int i = 0; i < 6; i++) begin
      set_a[i] = $random(seed);
      reg_write(field_offset(i), set_a[i]);
    end
    for (int i = 0; i < 6; i++) read_check(field_offset(i), set_a[i] & field_mask(i));
    read_check(12'h3fc, 32'd0); // past the last field
    read_check(12'h024, 32'd0);
    reg_write_np(ofs_perf_enable, 32'h1);
    read_check(ofs_perf_enable, 32'h1);
    end_test("readback");

    // set a to group 0, set b to group 1
    for (int i = 0; i < 6; i++) begin
      set_a[i] = $random(seed);
      set_b[i] = $random(seed);
      reg_write(field_offset(i), set_a[i]);
    end
    reg_write_np(ofs_pointer, 32'h1);
    for (int i = 0; i < 6; i++) reg_write(field_offset(i), set_b[i]);
    read_check(ofs_pointer, 32'h0000_0001); // producer 1, consumer 0
    check_cfg(reg2dp_cfg, expected_cfg(set_a));
    end_test("ping_pong");

    reg_write_np(ofs_pointer, 32'h0);
    reg_write_np(ofs_op_enable, 32'h1);
    check_word("reg2dp_op_en", 32'(reg2dp_op_en), 32'd0); // still in the pipe
    wait_op_en(1'b1);
    read_check(ofs_status, 32'h0000_0001);  // group 0 running, group 1 idle
    read_check(ofs_op_enable, 32'h1);
    end_test("arming");

    // armed group 0 ignores writes
    reg_write(ofs_misc_cfg, ~set_a[0]);
    reg_write(ofs_datain_size_0, ~set_a[1]);
    read_check(ofs_misc_cfg, set_a[0] & field_mask(0));
    read_check(ofs_datain_size_0, set_a[1] & field_mask(1));
    reg_write_np(ofs_pointer, 32'h1);
    set_b[2] = $random(seed);
    reg_write(ofs_datain_size_1, set_b[2]);
    read_check(ofs_datain_size_1, set_b[2] & field_mask(2));
    reg_write_np(ofs_op_enable, 32'h1);
    read_check(ofs_status, 32'h0002_0001);  // group 1 pending
    check_cfg(reg2dp_cfg, expected_cfg(set_a));
    end_test("write_protect");

    pulse_done();
    check_word("reg2dp_op_en", 32'(reg2dp_op_en), 32'd0);
    check_word("dp2reg_consumer", 32'(dp2reg_consumer), 32'd1);
    check_cfg(reg2dp_cfg, expected_cfg(set_b));
    wait_op_en(1'b1);                        // group 1 takes over
    read_check(ofs_status, 32'h0001_0000);
    read_check(ofs_pointer, 32'h0001_0001);
    reg_write_np(ofs_pointer, 32'h0);
    reg_write(ofs_misc_cfg, ~set_a[0]);      // group 0 free again
    read_check(ofs_misc_cfg, ~set_a[0] & field_mask(0));
    end_test("done_handover");

    check_word("slcg_op_en", 32'(slcg_op_en), 32'h7);
    pulse_done();
    repeat (5) @(negedge nvdla_core_clk);    // slcg trails the select by 3
    check_word("slcg_op_en", 32'(slcg_op_en), 32'h0);
    check_word("reg2dp_op_en", 32'(reg2dp_op_en), 32'd0);
    read_check(ofs_status, 32'h0000_0000);
    end_test("clock_gating");

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/rbk_reg_pkg.sv
rtl/rbk_csb_port.sv
rtl/rbk_pointer_group.sv
rtl/rbk_layer_group.sv
rtl/rbk_op_ctrl.sv
rtl/rbk_regfile.sv
bench/rbk_regfile_checker.sv
bench/rbk_regfile_tb.sv

// ==== Makefile ====
# verilator build, run and lint for the rubik register file

VERILATOR ?= verilator
TOP       ?= rbk_regfile_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the exact pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
